//--- muldiv_pkg.sv
package muldiv_pkg;

    // datapath width, RV32
    localparam int XLEN = 32;

    // operation code is funct3 of the M extension
    localparam int OP_W = 3;

    localparam logic [OP_W-1:0] OP_MUL    = 3'd0;
    localparam logic [OP_W-1:0] OP_MULH   = 3'd1;
    localparam logic [OP_W-1:0] OP_MULHSU = 3'd2;
    localparam logic [OP_W-1:0] OP_MULHU  = 3'd3;
    localparam logic [OP_W-1:0] OP_DIV    = 3'd4;
    localparam logic [OP_W-1:0] OP_DIVU   = 3'd5;
    localparam logic [OP_W-1:0] OP_REM    = 3'd6;
    localparam logic [OP_W-1:0] OP_REMU   = 3'd7;

    // one quotient bit per iteration
    localparam int DIV_STEPS = XLEN;
    localparam int DIV_CNT_W = $clog2(DIV_STEPS);

    // divider FSM encoding
    localparam int DIV_ST_W = 2;

    localparam logic [DIV_ST_W-1:0] DIV_IDLE    = 2'd0;
    localparam logic [DIV_ST_W-1:0] DIV_RUN     = 2'd1;  // shift-subtract loop
    localparam logic [DIV_ST_W-1:0] DIV_RESTORE = 2'd2;  // final remainder correction
    localparam logic [DIV_ST_W-1:0] DIV_SIGN    = 2'd3;  // signed result fix-up

    // req to done of the multiplier pipe
    localparam int MUL_LATENCY = 2;

endpackage

//--- div_if.sv
`timescale 1ns/100ps

interface div_if;
    import muldiv_pkg::*;

    logic            req;        // single-cycle pulse, divider idle
    logic            is_signed;
    logic [XLEN-1:0] dividend;
    logic [XLEN-1:0] divisor;

    logic [XLEN-1:0] quotient;   // valid with done, held until next req
    logic [XLEN-1:0] remainder;
    logic            done;

    modport ctrl (
        output req, is_signed, dividend, divisor,
        input  quotient, remainder, done
    );

    modport div (
        input  req, is_signed, dividend, divisor,
        output quotient, remainder, done
    );

endinterface

//--- mul_if.sv
`timescale 1ns/100ps

interface mul_if;
    import muldiv_pkg::*;

    logic              req;
    logic              a_signed;  // operand signedness for the high word
    logic              b_signed;
    logic [XLEN-1:0]   a;
    logic [XLEN-1:0]   b;

    logic [2*XLEN-1:0] product;   // full 64-bit result
    logic              done;      // MUL_LATENCY cycles after req

    modport ctrl (
        output req, a_signed, b_signed, a, b,
        input  product, done
    );

    modport mul (
        input  req, a_signed, b_signed, a, b,
        output product, done
    );

endinterface

//--- serial_divider.sv
`timescale 1ns/100ps

module serial_divider (
    input  logic clk_i,
    input  logic rst_i,
    div_if.div   dv
);
    import muldiv_pkg::*;

    logic [DIV_ST_W-1:0]  state_r;
    logic [DIV_CNT_W-1:0] cnt_r;
    logic                 sgn_op_r;
    logic                 done_r;

    logic [XLEN:0]        acc_r;      // partial remainder plus sign bit
    logic [XLEN-1:0]      quo_r;
    logic [XLEN-1:0]      dsr_r;      // divisor magnitude
    logic                 neg_dvd_r;
    logic                 neg_dsr_r;

    logic                 dvd_neg;
    logic                 dsr_neg;
    logic [XLEN-1:0]      dvd_mag;
    logic [XLEN-1:0]      dsr_mag;
    logic                 div_zero;
    logic                 sgn_ovf;
    logic                 small_u;
    logic                 special;
    logic [XLEN:0]        acc_shl;
    logic [XLEN:0]        acc_step;

    assign dvd_neg = dv.is_signed & dv.dividend[XLEN-1];
    assign dsr_neg = dv.is_signed & dv.divisor[XLEN-1];
    assign dvd_mag = dvd_neg ? -dv.dividend : dv.dividend;
    assign dsr_mag = dsr_neg ? -dv.divisor : dv.divisor;

    // results known without iterating
    assign div_zero = (dv.divisor == '0);
    assign sgn_ovf  = dv.is_signed && (&dv.divisor) &&
                      (dv.dividend == {1'b1, {(XLEN-1){1'b0}}});
    assign small_u  = !dv.is_signed && (dv.divisor > dv.dividend);
    assign special  = div_zero | sgn_ovf | small_u;

    // add back when the last partial remainder went negative
    assign acc_shl  = {acc_r[XLEN-1:0], quo_r[XLEN-1]};
    assign acc_step = acc_r[XLEN] ? acc_shl + {1'b0, dsr_r}
                                  : acc_shl - {1'b0, dsr_r};

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_r  <= DIV_IDLE;
            cnt_r    <= '0;
            sgn_op_r <= 1'b0;
            done_r   <= 1'b0;
        end else begin
            done_r <= 1'b0;
            case (state_r)
                DIV_IDLE: begin
                    if (dv.req) begin
                        if (special) begin
                            done_r <= 1'b1;
                        end else begin
                            cnt_r    <= DIV_CNT_W'(DIV_STEPS - 1);
                            sgn_op_r <= dv.is_signed;
                            state_r  <= DIV_RUN;
                        end
                    end
                end
                DIV_RUN: begin
                    cnt_r <= cnt_r - 1'b1;
                    if (cnt_r == '0) begin
                        state_r <= DIV_RESTORE;
                    end
                end
                DIV_RESTORE: begin
                    if (sgn_op_r) begin
                        state_r <= DIV_SIGN;
                    end else begin
                        done_r  <= 1'b1;
                        state_r <= DIV_IDLE;
                    end
                end
                default: begin  // DIV_SIGN
                    done_r  <= 1'b1;
                    state_r <= DIV_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        case (state_r)
            DIV_IDLE: begin
                if (dv.req) begin
                    if (div_zero) begin
                        quo_r <= '1;
                        acc_r <= {1'b0, dv.dividend};
                    end else if (sgn_ovf) begin
                        quo_r <= dv.dividend;
                        acc_r <= '0;
                    end else if (small_u) begin
                        quo_r <= '0;
                        acc_r <= {1'b0, dv.dividend};
                    end else begin
                        quo_r     <= dvd_mag;
                        acc_r     <= '0;
                        dsr_r     <= dsr_mag;
                        neg_dvd_r <= dvd_neg;
                        neg_dsr_r <= dsr_neg;
                    end
                end
            end
            DIV_RUN: begin
                acc_r <= acc_step;
                quo_r <= {quo_r[XLEN-2:0], ~acc_step[XLEN]};
            end
            DIV_RESTORE: begin
                if (acc_r[XLEN]) begin
                    acc_r <= acc_r + {1'b0, dsr_r};
                end
            end
            default: begin
                if (neg_dvd_r ^ neg_dsr_r) begin
                    quo_r <= -quo_r;
                end
                if (neg_dvd_r) begin  // remainder follows dividend sign
                    acc_r <= {1'b0, -acc_r[XLEN-1:0]};
                end
            end
        endcase
    end

    assign dv.quotient  = quo_r;
    assign dv.remainder = acc_r[XLEN-1:0];
    assign dv.done      = done_r;

    a_done_single: assert property (@(posedge clk_i) disable iff (!rst_i)
        dv.done |=> !dv.done);

    // controller must wait for done before the next request
    a_req_idle: assert property (@(posedge clk_i) disable iff (!rst_i)
        dv.req |-> (state_r == DIV_IDLE));

endmodule

//--- pipe_multiplier.sv
`timescale 1ns/100ps

module pipe_multiplier (
    input  logic clk_i,
    input  logic rst_i,
    mul_if.mul   mp
);
    import muldiv_pkg::*;

    logic signed [XLEN:0]     a_x;
    logic signed [XLEN:0]     b_x;
    logic signed [XLEN:0]     a_r;
    logic signed [XLEN:0]     b_r;
    logic signed [2*XLEN+1:0] prod_full;
    logic [2*XLEN-1:0]        prod_r;
    logic                     v1_r;
    logic                     done_r;

    // 33-bit extension lets all high-word variants share one signed multiply
    assign a_x = {mp.a_signed & mp.a[XLEN-1], mp.a};
    assign b_x = {mp.b_signed & mp.b[XLEN-1], mp.b};

    assign prod_full = a_r * b_r;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            v1_r   <= 1'b0;
            done_r <= 1'b0;
        end else begin
            v1_r   <= mp.req;
            done_r <= v1_r;
        end
    end

    // stage one operands
    always_ff @(posedge clk_i) begin
        if (mp.req) begin
            a_r <= a_x;
            b_r <= b_x;
        end
    end

    // stage two product, upper two bits are sign copies
    always_ff @(posedge clk_i) begin
        if (v1_r) begin
            prod_r <= prod_full[2*XLEN-1:0];
        end
    end

    assign mp.product = prod_r;
    assign mp.done    = done_r;

    a_fixed_latency: assert property (@(posedge clk_i) disable iff (!rst_i)
        mp.req |-> ##MUL_LATENCY mp.done);

endmodule

//--- muldiv_ctrl.sv
`timescale 1ns/100ps

module muldiv_ctrl (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        start_i,
    input  logic [muldiv_pkg::OP_W-1:0] op_i,
    input  logic [muldiv_pkg::XLEN-1:0] rs1_i,
    input  logic [muldiv_pkg::XLEN-1:0] rs2_i,
    output logic [muldiv_pkg::XLEN-1:0] result_o,
    output logic                        done_o,
    output logic                        busy_o,
    div_if.ctrl                         dv,
    mul_if.ctrl                         mp
);
    import muldiv_pkg::*;

    logic [OP_W-1:0] op_r;
    logic            accept;
    logic            is_div;
    logic            op_r_div;
    logic            unit_done;
    logic [XLEN-1:0] sel_word;

    assign accept   = start_i & ~busy_o;  // starts while busy are dropped
    assign is_div   = op_i inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
    assign op_r_div = op_r inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};

    assign mp.req      = accept & ~is_div;
    assign mp.a_signed = (op_i == OP_MULH) || (op_i == OP_MULHSU);
    assign mp.b_signed = (op_i == OP_MULH);
    assign mp.a        = rs1_i;
    assign mp.b        = rs2_i;

    assign dv.req       = accept & is_div;
    assign dv.is_signed = (op_i == OP_DIV) || (op_i == OP_REM);
    assign dv.dividend  = rs1_i;
    assign dv.divisor   = rs2_i;

    assign unit_done = op_r_div ? dv.done : mp.done;

    always_comb begin
        case (op_r)
            OP_MUL:                       sel_word = mp.product[XLEN-1:0];
            OP_MULH, OP_MULHSU, OP_MULHU: sel_word = mp.product[2*XLEN-1:XLEN];
            OP_DIV, OP_DIVU:              sel_word = dv.quotient;
            default:                      sel_word = dv.remainder;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            op_r     <= OP_MUL;
            busy_o   <= 1'b0;
            done_o   <= 1'b0;
            result_o <= '0;
        end else begin
            done_o <= 1'b0;
            if (accept) begin
                op_r   <= op_i;
                busy_o <= 1'b1;
            end else if (busy_o && unit_done) begin
                busy_o   <= 1'b0;
                done_o   <= 1'b1;
                result_o <= sel_word;
            end
        end
    end

    // every result belongs to an operation that was in flight
    a_done_after_busy: assert property (@(posedge clk_i) disable iff (!rst_i)
        done_o |-> $past(busy_o));

endmodule

//--- muldiv_unit.sv
`timescale 1ns/100ps

module muldiv_unit (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        start_i,
    input  logic [muldiv_pkg::OP_W-1:0] op_i,
    input  logic [muldiv_pkg::XLEN-1:0] rs1_i,
    input  logic [muldiv_pkg::XLEN-1:0] rs2_i,
    output logic [muldiv_pkg::XLEN-1:0] result_o,
    output logic                        done_o,
    output logic                        busy_o
);

    div_if div_bus ();
    mul_if mul_bus ();

    muldiv_ctrl u_ctrl (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .start_i  (start_i),
        .op_i     (op_i),
        .rs1_i    (rs1_i),
        .rs2_i    (rs2_i),
        .result_o (result_o),
        .done_o   (done_o),
        .busy_o   (busy_o),
        .dv       (div_bus.ctrl),
        .mp       (mul_bus.ctrl)
    );

    // variable latency
    serial_divider u_div (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .dv    (div_bus.div)
    );

    pipe_multiplier u_mul (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .mp    (mul_bus.mul)
    );

endmodule

//--- tb_muldiv.sv
`timescale 1ns/100ps

module tb_muldiv;
    import muldiv_pkg::*;

    localparam int TIMEOUT_CYC = 100;

    logic            clk_i;
    logic            rst_i;
    logic            start_i;
    logic [OP_W-1:0] op_i;
    logic [XLEN-1:0] rs1_i;
    logic [XLEN-1:0] rs2_i;
    logic [XLEN-1:0] result_o;
    logic            done_o;
    logic            busy_o;

    logic [15:0]     lfsr_state = 16'd22063;

    muldiv_unit UUT (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .start_i  (start_i),
        .op_i     (op_i),
        .rs1_i    (rs1_i),
        .rs2_i    (rs2_i),
        .result_o (result_o),
        .done_o   (done_o),
        .busy_o   (busy_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // 16-bit galois, taps 16 14 13 11
    function automatic logic next_bit();
        lfsr_state = {1'b0, lfsr_state[15:1]} ^ (lfsr_state[0] ? 16'hB400 : 16'h0000);
        return lfsr_state[0];
    endfunction

    function automatic logic [XLEN-1:0] rand_word();
        logic [XLEN-1:0] w;
        for (int i = 0; i < XLEN; i++) begin
            w[i] = next_bit();
        end
        return w;
    endfunction

    // expected RV32M result
    function automatic logic [XLEN-1:0] ref_result(input logic [OP_W-1:0] op,
                                                   input logic [XLEN-1:0] a,
                                                   input logic [XLEN-1:0] b);
        logic [2*XLEN-1:0] ax;
        logic [2*XLEN-1:0] bx;
        logic [2*XLEN-1:0] prod;
        logic [XLEN-1:0]   ma;
        logic [XLEN-1:0]   mb;
        logic [XLEN-1:0]   q;
        logic [XLEN-1:0]   r;
        logic              sgn;
        sgn  = (op == OP_DIV) || (op == OP_REM);
        ax   = (op == OP_MULH || op == OP_MULHSU) ? {{XLEN{a[XLEN-1]}}, a} : {{XLEN{1'b0}}, a};
        bx   = (op == OP_MULH) ? {{XLEN{b[XLEN-1]}}, b} : {{XLEN{1'b0}}, b};
        prod = ax * bx;
        ma   = (sgn && a[XLEN-1]) ? -a : a;
        mb   = (sgn && b[XLEN-1]) ? -b : b;
        if (b == '0) begin
            q = '1;
            r = a;
        end else if (sgn && a == {1'b1, {(XLEN-1){1'b0}}} && b == '1) begin
            q = a;
            r = '0;
        end else begin
            q = ma / mb;
            r = ma % mb;
            if (sgn && (a[XLEN-1] ^ b[XLEN-1])) q = -q;
            if (sgn && a[XLEN-1]) r = -r;  // sign of dividend
        end
        case (op)
            OP_MUL:                       return prod[XLEN-1:0];
            OP_MULH, OP_MULHSU, OP_MULHU: return prod[2*XLEN-1:XLEN];
            OP_DIV, OP_DIVU:              return q;
            default:                      return r;
        endcase
    endfunction

    task automatic check_word(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
            $display("*** FAILED ***");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
            $display("*** FAILED ***");
            $fatal(1);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
            $display("*** FAILED ***");
            $fatal(1);
        end
    endtask

    // called 1 ns after an edge, returns the same way
    task automatic run_op(input logic [OP_W-1:0] op, input logic [XLEN-1:0] a,
                          input logic [XLEN-1:0] b, output logic [XLEN-1:0] res,
                          output int cycles);
        int  n;
        logic seen;
        n       = 0;
        seen    = 1'b0;
        op_i    = op;
        rs1_i   = a;
        rs2_i   = b;
        start_i = 1'b1;
        while (!seen && n < TIMEOUT_CYC) begin
            @(posedge clk_i);
            #1;
            n++;
            start_i = 1'b0;
            seen    = done_o;
        end
        if (!seen) begin
            $display("no done_o within %0d cycles of starting op %0d", TIMEOUT_CYC, op);
            $display("*** FAILED ***");
            $fatal(1);
        end else begin
            res    = result_o;
            cycles = n;
        end
    endtask

    task automatic exec_and_compare(input logic [OP_W-1:0] op, input logic [XLEN-1:0] a,
                                    input logic [XLEN-1:0] b, output int cycles);
        logic [XLEN-1:0] res;
        run_op(op, a, b, res, cycles);
        check_word($sformatf("result_o op%0d a=%h b=%h", op, a, b), res, ref_result(op, a, b));
    endtask

    task automatic test_reset();
        check_flag("done_o", done_o, 1'b0);
        check_flag("busy_o", busy_o, 1'b0);
        check_word("result_o", result_o, '0);
    endtask

    task automatic test_mul();
        logic [XLEN-1:0] corner [4];
        logic [OP_W-1:0] op;
        int              cycles;
        corner = '{32'h0000_0000, 32'h0000_0001, 32'hFFFF_FFFF, 32'h8000_0000};
        for (int k = 0; k < 4; k++) begin
            op = OP_MUL + OP_W'(k);
            for (int i = 0; i < 16; i++) begin
                exec_and_compare(op, corner[i/4], corner[i%4], cycles);
                check_count("mul latency", cycles, MUL_LATENCY + 1);
            end
            for (int i = 0; i < 20; i++) begin
                exec_and_compare(op, rand_word(), rand_word(), cycles);
                check_count("mul latency", cycles, MUL_LATENCY + 1);
            end
        end
    endtask

    task automatic test_div();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        int              cycles;
        for (int k = 4; k < 8; k++) begin
            for (int combo = 0; combo < 4; combo++) begin
                for (int i = 0; i < 5; i++) begin
                    a = rand_word();
                    b = rand_word() >> (i * 6);  // spread divisor sizes
                    a[XLEN-1] = combo[1];
                    b[XLEN-1] = combo[0];
                    exec_and_compare(OP_W'(k), a, b, cycles);
                end
            end
        end
    endtask

    task automatic test_special();
        logic [XLEN-1:0] dvd [3];
        logic [XLEN-1:0] res;
        int              cycles;
        dvd = '{32'h1234_5678, 32'h8000_0000, 32'hFFFF_FFF9};
        for (int i = 0; i < 3; i++) begin
            run_op(OP_DIV, dvd[i], '0, res, cycles);
            check_word("result_o div by zero", res, 32'hFFFF_FFFF);
            run_op(OP_DIVU, dvd[i], '0, res, cycles);
            check_word("result_o divu by zero", res, 32'hFFFF_FFFF);
            run_op(OP_REM, dvd[i], '0, res, cycles);
            check_word("result_o rem by zero", res, dvd[i]);
            run_op(OP_REMU, dvd[i], '0, res, cycles);
            check_word("result_o remu by zero", res, dvd[i]);
        end
        run_op(OP_DIV, 32'h8000_0000, 32'hFFFF_FFFF, res, cycles);
        check_word("result_o div overflow", res, 32'h8000_0000);
        run_op(OP_REM, 32'h8000_0000, 32'hFFFF_FFFF, res, cycles);
        check_word("result_o rem overflow", res, 32'h0000_0000);
    endtask

    task automatic test_ignore_busy();
        logic [XLEN-1:0] res;
        int              cycles;
        int              dones;
        op_i    = OP_MUL;
        rs1_i   = 32'd3;
        rs2_i   = 32'd5;
        start_i = 1'b0;
        // second start lands two cycles into a long divide
        fork
            run_op(OP_DIVU, 32'h7FFF_1234, 32'd7, res, cycles);
            begin
                repeat (2) @(posedge clk_i);
                #2;
                check_flag("busy_o", busy_o, 1'b1);
                op_i    = OP_MUL;
                rs1_i   = 32'd3;
                rs2_i   = 32'd5;
                start_i = 1'b1;
                @(posedge clk_i);
                #2;
                start_i = 1'b0;
            end
        join
        check_word("result_o after ignored start", res, ref_result(OP_DIVU, 32'h7FFF_1234, 32'd7));
        dones = 0;
        repeat (40) begin
            @(posedge clk_i);
            #1;
            if (done_o) dones++;
        end
        check_count("extra done_o pulses", dones, 0);
        check_flag("busy_o", busy_o, 1'b0);
    endtask

    task automatic test_back_to_back();
        int cycles;
        exec_and_compare(OP_DIV, 32'hF123_4567, 32'h0000_0123, cycles);
        exec_and_compare(OP_MUL, 32'hDEAD_BEEF, 32'h0000_1234, cycles);
        exec_and_compare(OP_REM, 32'h7654_3210, 32'hFFFF_FF81, cycles);
        exec_and_compare(OP_MULHSU, 32'h8765_4321, 32'hFEDC_BA98, cycles);
    endtask

    initial begin
        rst_i   = 1'b0;
        start_i = 1'b0;
        op_i    = OP_MUL;
        rs1_i   = '0;
        rs2_i   = '0;
        repeat (5) @(posedge clk_i);
        #1;
        rst_i = 1'b1;
        test_reset();
        test_mul();
        test_div();
        test_special();
        test_ignore_busy();
        test_back_to_back();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- files.f
muldiv_pkg.sv
div_if.sv
mul_if.sv
serial_divider.sv
pipe_multiplier.sv
muldiv_ctrl.sv
muldiv_unit.sv
tb_muldiv.sv

//--- Bender.yml
package:
  name: muldiv

sources:
  - muldiv_pkg.sv
  - div_if.sv
  - mul_if.sv
  - serial_divider.sv
  - pipe_multiplier.sv
  - muldiv_ctrl.sv
  - muldiv_unit.sv
  - target: test
    files:
      - tb_muldiv.sv
